// File: list.f
src/dcache_pkg.sv
src/dcache_ifs.sv
src/cache_array.sv
src/plru_tree.sv
src/miss_buffer.sv
src/load_result.sv
src/dcache_top.sv
verification/dcache_chk.sv
verification/dcache_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module dcache_tb -o sim_dcache
out=$(./obj_dir/sim_dcache 2>&1) || true
echo "$out"
if echo "$out" | grep -q "Testbench passed"; then
    exit 0
else
    exit 1
fi

// File: src/cache_array.sv
`timescale 1ns/1ns

module cache_array (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                load_valid,
    input  logic [dcache_pkg::addr_width-1:0]   load_addr,
    input  logic                                store_valid,
    input  logic [dcache_pkg::addr_width-1:0]   store_addr,
    input  dcache_pkg::access_size_e            store_size,
    input  logic [dcache_pkg::word_width-1:0]   store_data,
    fill_if.array                               fill,
    lookup_if.array                             lookup,
    input  logic [dcache_pkg::way_width-1:0]    victim_way
);
    import dcache_pkg::*;

    cache_line_t [num_ways-1:0] lines [num_sets];

    logic [set_width-1:0]    load_set;
    logic [set_width-1:0]    store_set;
    logic [offset_width-1:0] store_offset;
    logic [way_width:0]      load_match;
    logic [way_width:0]      store_match;
    logic [way_width:0]      fill_match;
    logic [way_width-1:0]    fill_way;
    logic                    load_hit;

    // {hit, way} of a tag within one set
    function automatic logic [way_width:0] match_way(
        input cache_line_t [num_ways-1:0] ways,
        input logic [tag_width-1:0] tag
    );
        logic [way_width:0] found;
        found = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (ways[w].valid && ways[w].tag == tag) begin
                found = {1'b1, way_width'(w)};
            end
        end
        return found;
    endfunction

    assign load_set = load_addr[offset_width +: set_width];
    assign store_set = store_addr[offset_width +: set_width];
    assign store_offset = store_addr[offset_width-1:0];

    assign load_match = match_way(lines[load_set], load_addr[addr_width-1 -: tag_width]);
    assign store_match = match_way(lines[store_set], store_addr[addr_width-1 -: tag_width]);
    assign fill_match = match_way(lines[fill.head_set], fill.head_tag);

    // reuse a copy already present, else lowest invalid way, else the plru pick
    always_comb begin
        fill_way = victim_way;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!lines[fill.head_set][w].valid) begin
                fill_way = way_width'(w);
            end
        end
        if (fill_match[way_width]) begin
            fill_way = fill_match[way_width-1:0];
        end
    end

    assign load_hit = load_valid && load_match[way_width];
    assign lookup.load_hit = load_hit;
    assign lookup.load_way = load_hit ? load_match[way_width-1:0] : fill_way;
    assign lookup.load_data = lines[load_set][load_match[way_width-1:0]].data;
    assign lookup.store_hit = store_valid && store_match[way_width];
    assign lookup.store_way = store_match[way_width-1:0];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    lines[s][w].valid <= 1'b0;
                end
            end
        end else begin
            // write-through store only touches a line that is present
            if (lookup.store_hit) begin
                case (store_size)
                    byte_access: lines[store_set][store_match[way_width-1:0]]
                        .data[{store_offset, 3'b000} +: 8] <= store_data[7:0];
                    half_access: lines[store_set][store_match[way_width-1:0]]
                        .data[{store_offset[2:1], 4'b0000} +: 16] <= store_data[15:0];
                    default: lines[store_set][store_match[way_width-1:0]]
                        .data[{store_offset[2], 5'b00000} +: 32] <= store_data;
                endcase
            end
            if (fill.pop) begin
                lines[fill.head_set][fill_way] <= '{1'b1, fill.head_tag, fill.head_data};
            end
        end
    end

endmodule

// File: src/dcache_ifs.sv
`timescale 1ns/1ns

// tag lookup results for the current load and store
interface lookup_if;
    import dcache_pkg::*;

    logic                   load_hit;
    // on a miss cycle this carries the way being filled
    logic [way_width-1:0]   load_way;
    logic [block_width-1:0] load_data;
    logic                   store_hit;
    logic [way_width-1:0]   store_way;

    modport array (
        output load_hit, load_way, load_data, store_hit, store_way
    );

    modport consumer (
        input load_hit, load_data
    );

    modport buffer (
        input load_hit
    );
endinterface

// oldest miss-buffer entry, offered for delivery and fill
interface fill_if;
    import dcache_pkg::*;

    logic                    head_done;
    logic [set_width-1:0]    head_set;
    logic [tag_width-1:0]    head_tag;
    logic [block_width-1:0]  head_data;
    logic [offset_width-1:0] head_offset;
    access_size_e            head_size;
    logic                    head_signed;
    logic [dest_width-1:0]   head_dest;
    logic                    pop;

    modport buffer (
        output head_done, head_set, head_tag, head_data, head_offset,
        output head_size, head_signed, head_dest
    );

    modport array (
        input head_set, head_tag, head_data, pop
    );

    modport result (
        input head_done, head_data, head_offset, head_size, head_signed, head_dest
    );
endinterface

// File: src/dcache_pkg.sv
package dcache_pkg;

    // address split is {tag, set, offset}
    localparam int addr_width = 16;
    localparam int tag_width = 10;
    localparam int set_width = 3;
    localparam int offset_width = 3;

    // geometry
    localparam int num_sets = 8;
    localparam int num_ways = 4;
    localparam int way_width = 2;
    localparam int block_width = 64;

    // datapath widths
    localparam int word_width = 32;
    localparam int dest_width = 6;

    // a zero memory transaction tag means no transaction
    localparam int mem_tag_width = 4;

    // load and store sizes; a block read always returns the full line
    typedef enum logic [1:0] {
        byte_access,
        half_access,
        word_access
    } access_size_e;

    typedef enum logic [1:0] {
        bus_none,
        bus_load,
        bus_store
    } bus_command_e;

    typedef struct packed {
        logic                   valid;
        logic [tag_width-1:0]   tag;
        logic [block_width-1:0] data;
    } cache_line_t;

endpackage

// File: src/dcache_top.sv
`timescale 1ns/1ns

module dcache_top #(
    parameter int load_buffer_depth = 4
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    load_valid,
    input  logic [dcache_pkg::addr_width-1:0]       load_addr,
    input  dcache_pkg::access_size_e                load_size,
    input  logic                                    load_signed,
    input  logic [dcache_pkg::dest_width-1:0]       load_dest,
    input  logic                                    store_valid,
    input  logic [dcache_pkg::addr_width-1:0]       store_addr,
    input  dcache_pkg::access_size_e                store_size,
    input  logic [dcache_pkg::word_width-1:0]       store_data,
    input  logic [dcache_pkg::mem_tag_width-1:0]    mem_response,
    input  logic [dcache_pkg::mem_tag_width-1:0]    mem_data_tag,
    input  logic [dcache_pkg::block_width-1:0]      mem_data,
    input  logic                                    flush,
    output logic                                    result_valid,
    output logic [dcache_pkg::word_width-1:0]       result_value,
    output logic [dcache_pkg::dest_width-1:0]       result_dest,
    output dcache_pkg::bus_command_e                mem_command,
    output logic [dcache_pkg::addr_width-1:0]       mem_addr,
    output dcache_pkg::access_size_e                mem_size,
    output logic [dcache_pkg::word_width-1:0]       mem_data_out
);
    import dcache_pkg::*;

    lookup_if lookup ();
    fill_if   fill ();

    logic [way_width-1:0] lru_way;
    logic                 hit_taken;
    logic [set_width-1:0] plru_load_set;

    // hit updates the load's set, otherwise the filled head's set
    assign plru_load_set = hit_taken ? load_addr[offset_width +: set_width] : fill.head_set;

    cache_array u_array (
        .clock       (clock),
        .reset       (reset),
        .load_valid  (load_valid),
        .load_addr   (load_addr),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_size  (store_size),
        .store_data  (store_data),
        .fill        (fill.array),
        .lookup      (lookup.array),
        .victim_way  (lru_way)
    );

    plru_tree u_plru (
        .clock        (clock),
        .reset        (reset),
        .lookup_set   (fill.head_set),
        .load_update  (hit_taken || fill.pop),
        .load_set     (plru_load_set),
        .load_way     (lookup.load_way),
        .store_update (lookup.store_hit),
        .store_set    (store_addr[offset_width +: set_width]),
        .store_way    (lookup.store_way),
        .lru_way      (lru_way)
    );

    miss_buffer #(
        .load_buffer_depth (load_buffer_depth)
    ) u_miss_buffer (
        .clock        (clock),
        .reset        (reset),
        .flush        (flush),
        .load_valid   (load_valid),
        .load_addr    (load_addr),
        .load_size    (load_size),
        .load_signed  (load_signed),
        .load_dest    (load_dest),
        .store_valid  (store_valid),
        .store_addr   (store_addr),
        .store_size   (store_size),
        .store_data   (store_data),
        .lookup       (lookup.buffer),
        .fill         (fill.buffer),
        .hit_taken    (hit_taken),
        .mem_response (mem_response),
        .mem_data_tag (mem_data_tag),
        .mem_data     (mem_data),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_size     (mem_size),
        .mem_data_out (mem_data_out)
    );

    load_result u_result (
        .lookup       (lookup.consumer),
        .fill         (fill.result),
        .load_valid   (load_valid),
        .load_addr    (load_addr),
        .load_size    (load_size),
        .load_signed  (load_signed),
        .load_dest    (load_dest),
        .result_valid (result_valid),
        .result_value (result_value),
        .result_dest  (result_dest),
        .hit_taken    (hit_taken),
        .pop          (fill.pop)
    );

endmodule

// File: src/load_result.sv
`timescale 1ns/1ns

module load_result (
    lookup_if.consumer                          lookup,
    fill_if.result                              fill,
    input  logic                                load_valid,
    input  logic [dcache_pkg::addr_width-1:0]   load_addr,
    input  dcache_pkg::access_size_e            load_size,
    input  logic                                load_signed,
    input  logic [dcache_pkg::dest_width-1:0]   load_dest,
    output logic                                result_valid,
    output logic [dcache_pkg::word_width-1:0]   result_value,
    output logic [dcache_pkg::dest_width-1:0]   result_dest,
    output logic                                hit_taken,
    output logic                                pop
);
    import dcache_pkg::*;

    logic [block_width-1:0]  line;
    logic [block_width-1:0]  shifted;
    logic [offset_width-1:0] offset;
    access_size_e            size;
    logic                    sign;

    // a hit goes first and the done head waits a cycle
    assign hit_taken = load_valid && lookup.load_hit;
    assign pop = fill.head_done && !hit_taken;
    assign result_valid = hit_taken || fill.head_done;

    assign line = hit_taken ? lookup.load_data : fill.head_data;
    assign offset = hit_taken ? load_addr[offset_width-1:0] : fill.head_offset;
    assign size = hit_taken ? load_size : fill.head_size;
    assign sign = hit_taken ? load_signed : fill.head_signed;
    assign result_dest = hit_taken ? load_dest : fill.head_dest;

    // accesses are naturally aligned
    assign shifted = line >> {offset, 3'b000};

    always_comb begin
        case (size)
            byte_access: result_value = {{24{sign && shifted[7]}}, shifted[7:0]};
            half_access: result_value = {{16{sign && shifted[15]}}, shifted[15:0]};
            default: result_value = shifted[31:0];
        endcase
    end

endmodule

// File: src/miss_buffer.sv
`timescale 1ns/1ns

module miss_buffer #(
    parameter int load_buffer_depth = 4
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    flush,
    input  logic                                    load_valid,
    input  logic [dcache_pkg::addr_width-1:0]       load_addr,
    input  dcache_pkg::access_size_e                load_size,
    input  logic                                    load_signed,
    input  logic [dcache_pkg::dest_width-1:0]       load_dest,
    input  logic                                    store_valid,
    input  logic [dcache_pkg::addr_width-1:0]       store_addr,
    input  dcache_pkg::access_size_e                store_size,
    input  logic [dcache_pkg::word_width-1:0]       store_data,
    lookup_if.buffer                                lookup,
    fill_if.buffer                                  fill,
    input  logic                                    hit_taken,
    input  logic [dcache_pkg::mem_tag_width-1:0]    mem_response,
    input  logic [dcache_pkg::mem_tag_width-1:0]    mem_data_tag,
    input  logic [dcache_pkg::block_width-1:0]      mem_data,
    output dcache_pkg::bus_command_e                mem_command,
    output logic [dcache_pkg::addr_width-1:0]       mem_addr,
    output dcache_pkg::access_size_e                mem_size,
    output logic [dcache_pkg::word_width-1:0]       mem_data_out
);
    import dcache_pkg::*;

    localparam int ptr_width = $clog2(load_buffer_depth);

    logic [load_buffer_depth-1:0] entry_valid;
    logic [load_buffer_depth-1:0] entry_done;
    logic [load_buffer_depth-1:0] entry_signed;
    logic [addr_width-1:0]        entry_addr [load_buffer_depth];
    access_size_e                 entry_size [load_buffer_depth];
    logic [dest_width-1:0]        entry_dest [load_buffer_depth];
    // zero until memory accepts the request
    logic [mem_tag_width-1:0]     entry_tag [load_buffer_depth];
    logic [block_width-1:0]       entry_data [load_buffer_depth];

    logic [ptr_width-1:0] head;
    logic [ptr_width-1:0] send;
    logic [ptr_width-1:0] tail;
    logic                 head_ready;
    logic                 request_load;

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        return (ptr == ptr_width'(load_buffer_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // a flush cycle neither delivers nor requests
    assign head_ready = entry_valid[head] && entry_done[head] && !flush;
    assign request_load = entry_valid[send] && entry_tag[send] == '0 && !flush;

    assign fill.head_done = head_ready;
    assign fill.head_set = entry_addr[head][offset_width +: set_width];
    assign fill.head_tag = entry_addr[head][addr_width-1 -: tag_width];
    assign fill.head_data = entry_data[head];
    assign fill.head_offset = entry_addr[head][offset_width-1:0];
    assign fill.head_size = entry_size[head];
    assign fill.head_signed = entry_signed[head];
    assign fill.head_dest = entry_dest[head];

    // stores always win the memory port
    always_comb begin
        if (store_valid) begin
            mem_command = bus_store;
            mem_addr = store_addr;
            mem_size = store_size;
        end else begin
            mem_command = request_load ? bus_load : bus_none;
            mem_addr = {entry_addr[send][addr_width-1:offset_width], {offset_width{1'b0}}};
            mem_size = word_access;
        end
    end
    assign mem_data_out = store_data;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            entry_valid <= '0;
            entry_done <= '0;
            head <= '0;
            send <= '0;
            tail <= '0;
        end else begin
            // capture returned blocks by transaction tag
            for (int i = 0; i < load_buffer_depth; i++) begin
                if (entry_valid[i] && !entry_done[i] && mem_data_tag != '0
                        && entry_tag[i] == mem_data_tag) begin
                    entry_done[i] <= 1'b1;
                    entry_data[i] <= mem_data;
                end
            end
            if (mem_command == bus_load && mem_response != '0) begin
                entry_tag[send] <= mem_response;
                send <= next_ptr(send);
            end
            if (head_ready && !hit_taken) begin
                entry_valid[head] <= 1'b0;
                head <= next_ptr(head);
            end
            if (load_valid && !lookup.load_hit) begin
                entry_valid[tail] <= 1'b1;
                entry_done[tail] <= 1'b0;
                entry_addr[tail] <= load_addr;
                entry_size[tail] <= load_size;
                entry_signed[tail] <= load_signed;
                entry_dest[tail] <= load_dest;
                entry_tag[tail] <= '0;
                tail <= next_ptr(tail);
            end
        end
    end

endmodule

// File: src/plru_tree.sv
`timescale 1ns/1ns

module plru_tree (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [dcache_pkg::set_width-1:0]    lookup_set,
    input  logic                                load_update,
    input  logic [dcache_pkg::set_width-1:0]    load_set,
    input  logic [dcache_pkg::way_width-1:0]    load_way,
    input  logic                                store_update,
    input  logic [dcache_pkg::set_width-1:0]    store_set,
    input  logic [dcache_pkg::way_width-1:0]    store_way,
    output logic [dcache_pkg::way_width-1:0]    lru_way
);
    import dcache_pkg::*;

    // bit 0 is the root, bit 1 picks in ways 0/1, bit 2 picks in ways 2/3
    logic [2:0] trees [num_sets];

    // turn the root and the pair bit away from the accessed way
    function automatic logic [2:0] touch(
        input logic [2:0] tree,
        input logic [way_width-1:0] way
    );
        logic [2:0] next;
        next = tree;
        if (way[1]) begin
            next[0] = 1'b0;
            next[2] = ~way[0];
        end else begin
            next[0] = 1'b1;
            next[1] = ~way[0];
        end
        return next;
    endfunction

    assign lru_way = trees[lookup_set][0] ? {1'b1, trees[lookup_set][2]}
                                          : {1'b0, trees[lookup_set][1]};

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                trees[s] <= 3'b000;
            end
        end else if (load_update) begin
            trees[load_set] <= touch(trees[load_set], load_way);
        end else if (store_update) begin
            trees[store_set] <= touch(trees[store_set], store_way);
        end
    end

endmodule

// File: verification/dcache_chk.sv
`timescale 1ns/1ns

module dcache_chk (
    input logic                             clock,
    input logic                             reset,
    input logic                             store_valid,
    input dcache_pkg::bus_command_e         mem_command,
    input logic                             result_valid,
    input logic [dcache_pkg::dest_width-1:0] result_dest
);
    import dcache_pkg::*;

    // memory port idle right after reset
    assert property (@(posedge clock) $fell(reset) |-> mem_command == bus_none)
        else $error("memory command active after reset");

    // stores go out in their own cycle
    assert property (@(posedge clock) disable iff (reset)
        store_valid |-> mem_command == bus_store)
        else $error("store did not reach the memory port");

    assert property (@(posedge clock) disable iff (reset)
        result_valid |-> !$isunknown(result_dest))
        else $error("result dest has unknown bits");

endmodule

bind dcache_top dcache_chk chk (
    .clock        (clock),
    .reset        (reset),
    .store_valid  (store_valid),
    .mem_command  (mem_command),
    .result_valid (result_valid),
    .result_dest  (result_dest)
);

// File: verification/dcache_stim.txt
# op addr size signed data_or_dest check expect (hex: addr, data, expect)
# op L load S store F flush D drain; size 0 byte 1 half 2 word; check 0 uses shadow memory
L 0040 0 0 01 0 0
D 0000 0 0 00 0 0
L 0041 0 1 02 0 0
L 0042 1 1 03 0 0
L 0044 2 0 04 0 0
S 0044 2 0 cafe1234 0 0
L 0044 2 0 05 1 cafe1234
S 0100 2 0 12345678 0 0
S 0104 1 0 0000beef 0 0
L 0103 0 1 06 1 00000012
L 0104 1 1 07 1 ffffbeef
L 0105 0 0 08 1 000000be
D 0000 0 0 00 0 0
L 0200 2 0 09 0 0
L 0300 2 1 0a 0 0
L 0404 1 0 0b 0 0
L 0040 0 1 0c 0 0
L 0100 2 0 0d 1 12345678
D 0000 0 0 00 0 0
L 0508 2 0 10 0 0
L 0610 2 0 11 0 0
L 0718 2 0 12 0 0
L 0820 2 0 13 0 0
L 0928 2 0 14 0 0
D 0000 0 0 00 0 0
L 0a00 2 0 15 0 0
L 0b00 2 0 16 0 0
F 0000 0 0 00 0 0
L 0a00 2 0 17 0 0
L 0b04 1 1 18 0 0
D 0000 0 0 00 0 0

// File: verification/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;
    import dcache_pkg::*;

    localparam int credit_limit = 4;
    localparam int max_ops = 64;

    logic                     clock = 1'b0;
    logic                     reset = 1'b1;
    logic                     load_valid = 1'b0;
    logic [addr_width-1:0]    load_addr = '0;
    access_size_e             load_size = byte_access;
    logic                     load_signed = 1'b0;
    logic [dest_width-1:0]    load_dest = '0;
    logic                     store_valid = 1'b0;
    logic [addr_width-1:0]    store_addr = '0;
    access_size_e             store_size = byte_access;
    logic [word_width-1:0]    store_data = '0;
    logic [mem_tag_width-1:0] mem_response = 4'd1;
    logic [mem_tag_width-1:0] mem_data_tag = '0;
    logic [block_width-1:0]   mem_data = '0;
    logic                     flush = 1'b0;
    logic                     result_valid;
    logic [word_width-1:0]    result_value;
    logic [dest_width-1:0]    result_dest;
    bus_command_e             mem_command;
    logic [addr_width-1:0]    mem_addr;
    access_size_e             mem_size;
    logic [word_width-1:0]    mem_data_out;

    // memory seen by the bus, and the value the stimulus expects
    logic [7:0] memory [65536];
    logic [7:0] shadow [65536];

    // parsed stimulus with op 0 load, 1 store, 2 flush and 3 drain
    int              op_kind [max_ops];
    logic [15:0]     op_addr [max_ops];
    int              op_size [max_ops];
    logic            op_signed [max_ops];
    logic [31:0]     op_data [max_ops];
    logic            op_check [max_ops];
    logic [31:0]     op_expect [max_ops];
    int              op_count = 0;
    int              op_index = 0;

    int              cycle = 0;
    int              cycle_limit = 0;
    int              credits = credit_limit;
    logic            pending [64];
    logic [31:0]     expected [64];
    logic [15:0]     dest_addr [64];
    logic [5:0]      miss_q [$];
    logic [3:0]      ret_tag [$];
    logic [15:0]     ret_addr [$];
    int              ret_due [$];
    logic [3:0]      next_tag = 4'd1;

    // blocks filled so far, and distinct fills per set
    bit              block_seen [8192];
    int              set_fills [8];
    // outcome due for the load on the bus
    int              hit_due = 0;

    dcache_top #(.load_buffer_depth(credit_limit)) dut (.*);

    always #5 clock = ~clock;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // little-endian value of the shadow memory, extended to 32 bits
    function automatic logic [31:0] expected_load(input logic [15:0] a, input int sz,
                                                  input logic sgn);
        logic [31:0] raw;
        int base;
        base = int'(a);
        raw = {shadow[(base + 3) % 65536], shadow[(base + 2) % 65536],
               shadow[(base + 1) % 65536], shadow[base]};
        case (sz)
            0: return {{24{sgn && raw[7]}}, raw[7:0]};
            1: return {{16{sgn && raw[15]}}, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    // 0 must miss, 1 must hit, 2 either once the set may have evicted
    function automatic int load_outcome(input logic [15:0] a);
        if (!block_seen[a[15:3]]) begin
            return 0;
        end
        return (set_fills[a[5:3]] <= num_ways) ? 1 : 2;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] wanted,
                               input string what);
        if (actual !== wanted) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, actual, wanted);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "run aborted");
    endtask

    initial begin
        int fd;
        int n;
        string line;
        logic [7:0] op_c;
        logic [31:0] state;
        state = 32'd4;
        for (int i = 0; i < 65536; i++) begin
            state = lcg_next(state);
            memory[i] = state[23:16];
            shadow[i] = state[23:16];
        end
        for (int d = 0; d < 64; d++) begin
            pending[d] = 1'b0;
        end
        fd = $fopen("verification/dcache_stim.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file");
        end
        while (!$feof(fd) && op_count < max_ops) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %d %d %h %d %h", op_c, op_addr[op_count],
                            op_size[op_count], op_signed[op_count], op_data[op_count],
                            op_check[op_count], op_expect[op_count]);
                op_kind[op_count] = (op_c == "L") ? 0 : (op_c == "S") ? 1 :
                                    (op_c == "F") ? 2 : 3;
                op_count++;
            end
        end
        $fclose(fd);
        cycle_limit = 20 * op_count;
    end

    always @(posedge clock) begin
        logic hit;
        logic [15:0] filled_addr;
        cycle++;
        if (cycle >= cycle_limit) begin
            abort_run("timeout: the run did not finish within the cycle limit");
        end
        if (cycle == 3) begin
            reset <= 1'b0;
        end
        if (!reset) begin
            // results of the cycle that just ended
            if (load_valid && hit_due == 1
                    && !(result_valid && result_dest == load_dest)) begin
                abort_run("a load to a cached block did not hit in its own cycle");
            end
            if (load_valid && hit_due == 0 && result_valid && result_dest == load_dest) begin
                abort_run("a load to a block that was never filled hit");
            end
            hit = result_valid && load_valid && result_dest == load_dest;
            if (result_valid) begin
                if (!pending[result_dest]) begin
                    abort_run("a result came back for a dest that was not outstanding");
                end
                if (!hit) begin
                    if (miss_q.size() == 0 || miss_q[0] != result_dest) begin
                        abort_run("a miss result came back out of order");
                    end
                    void'(miss_q.pop_front());
                    // the delivered miss fills its block
                    filled_addr = dest_addr[result_dest];
                    if (!block_seen[filled_addr[15:3]]) begin
                        block_seen[filled_addr[15:3]] = 1'b1;
                        set_fills[filled_addr[5:3]]++;
                    end
                end
                check_value(result_value, expected[result_dest], "load result");
                pending[result_dest] = 1'b0;
                credits++;
            end
            if (load_valid && !hit) begin
                miss_q.push_back(load_dest);
            end
            if (flush) begin
                miss_q.delete();
                for (int d = 0; d < 64; d++) begin
                    pending[d] = 1'b0;
                end
                credits = credit_limit;
            end

            // memory model
            if (mem_command == bus_store) begin
                memory[mem_addr] = mem_data_out[7:0];
                if (mem_size != byte_access) begin
                    memory[mem_addr + 16'd1] = mem_data_out[15:8];
                end
                if (mem_size == word_access) begin
                    memory[mem_addr + 16'd2] = mem_data_out[23:16];
                    memory[mem_addr + 16'd3] = mem_data_out[31:24];
                end
            end else if (mem_command == bus_load) begin
                ret_tag.push_back(mem_response);
                ret_addr.push_back(mem_addr);
                ret_due.push_back(cycle + 3);
                next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                mem_response <= next_tag;
            end
            if (ret_due.size() > 0 && ret_due[0] <= cycle) begin
                mem_data_tag <= ret_tag.pop_front();
                for (int b = 0; b < 8; b++) begin
                    mem_data[b*8 +: 8] <= memory[ret_addr[0] + 16'(b)];
                end
                void'(ret_addr.pop_front());
                void'(ret_due.pop_front());
            end else begin
                mem_data_tag <= '0;
            end

            // stimulus
            load_valid <= 1'b0;
            store_valid <= 1'b0;
            flush <= 1'b0;
            if (op_index < op_count) begin
                case (op_kind[op_index])
                    0: begin
                        // hold the load back without a credit
                        if (credits > 0) begin
                            load_valid <= 1'b1;
                            load_addr <= op_addr[op_index];
                            load_size <= access_size_e'(op_size[op_index][1:0]);
                            load_signed <= op_signed[op_index];
                            load_dest <= op_data[op_index][5:0];
                            pending[op_data[op_index][5:0]] = 1'b1;
                            dest_addr[op_data[op_index][5:0]] = op_addr[op_index];
                            hit_due = load_outcome(op_addr[op_index]);
                            expected[op_data[op_index][5:0]] = op_check[op_index] ?
                                op_expect[op_index] :
                                expected_load(op_addr[op_index], op_size[op_index],
                                              op_signed[op_index]);
                            credits--;
                            op_index++;
                        end
                    end
                    1: begin
                        store_valid <= 1'b1;
                        store_addr <= op_addr[op_index];
                        store_size <= access_size_e'(op_size[op_index][1:0]);
                        store_data <= op_data[op_index];
                        shadow[op_addr[op_index]] = op_data[op_index][7:0];
                        if (op_size[op_index] > 0) begin
                            shadow[op_addr[op_index] + 16'd1] = op_data[op_index][15:8];
                        end
                        if (op_size[op_index] > 1) begin
                            shadow[op_addr[op_index] + 16'd2] = op_data[op_index][23:16];
                            shadow[op_addr[op_index] + 16'd3] = op_data[op_index][31:24];
                        end
                        op_index++;
                    end
                    2: begin
                        flush <= 1'b1;
                        op_index++;
                    end
                    default: begin
                        if (credits == credit_limit) begin
                            op_index++;
                        end
                    end
                endcase
            end else if (credits == credit_limit && !load_valid) begin
                $display("Testbench passed");
                $finish;
            end
        end
    end

endmodule
